// File: rv_exec_cases.txt
# hex columns: flush valid op cond op1_src op2_src rs1 rs2 rd reg_write imm pc
# then the expected result, redirect and target of that micro-op.
0 1 0 0 0 0 1e 1f 13 1 00000000 00000000 00000000 0 00000000
0 1 0 0 0 1 00 00 01 1 0000000f 00000000 0000000f 0 0000000f
0 1 0 0 0 1 00 00 02 1 fffffff0 00000000 fffffff0 0 fffffff0
0 1 0 0 0 1 00 00 03 1 00000004 00000000 00000004 0 00000004
0 1 0 0 0 0 01 02 04 1 00000000 00000000 ffffffff 0 00000000
0 1 1 0 0 0 04 01 05 1 00000000 00000000 fffffff0 0 00000000
0 1 2 0 0 0 04 01 06 1 00000000 00000000 0000000f 0 00000000
0 1 3 0 0 0 01 02 07 1 00000000 00000000 ffffffff 0 00000000
0 1 4 0 0 0 02 03 08 1 00000000 00000000 fffffff4 0 00000000
0 1 5 0 0 0 02 01 09 1 00000000 00000000 00000001 0 00000000
0 1 6 0 0 0 02 01 0a 1 00000000 00000000 00000000 0 00000000
0 1 7 0 0 0 01 03 0b 1 00000000 00000000 000000f0 0 00000000
0 1 8 0 0 0 02 03 0c 1 00000000 00000000 0fffffff 0 00000000
0 1 0 0 0 1 00 00 00 1 00000055 00000000 00000055 0 00000055
0 1 0 0 0 0 00 00 0d 1 00000000 00000000 00000000 0 00000000
0 1 0 1 0 0 01 01 00 0 00000020 00000100 0000001e 1 00000120
0 1 0 1 0 0 01 02 00 0 00000010 00000104 ffffffff 0 00000114
0 1 0 2 0 0 01 02 00 0 fffffff8 00000108 ffffffff 1 00000100
0 1 0 2 0 0 01 01 00 0 00000008 0000010c 0000001e 0 00000114
0 1 0 3 0 0 02 01 00 0 00000040 00000110 ffffffff 1 00000150
0 1 0 3 0 0 01 02 00 0 00000004 00000114 ffffffff 0 00000118
0 1 0 4 1 1 00 00 0e 1 00000100 00000200 00000204 1 00000300
0 1 0 5 0 1 0e 00 0f 1 00000011 00000300 00000304 1 00000214
0 1 0 0 0 1 00 00 10 1 00000111 00000000 00000111 0 00000111
0 1 0 0 0 1 00 00 11 1 00000222 00000000 00000222 0 00000222
1 1 0 0 0 1 00 00 10 1 00000333 00000000 00000333 0 00000333
0 0 0 0 0 0 00 00 00 0 00000000 00000000 00000000 0 00000000
0 1 0 0 0 0 10 11 12 1 00000000 00000000 00000111 0 00000000

// File: vlog.f
rv_exec_pkg.sv
rv_pipe_if.sv
rv_regfile.sv
rv_issue.sv
rv_operand_stage.sv
rv_alu_stage.sv
rv_exec_top.sv
tb_rv_exec.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing -f vlog.f --top-module tb_rv_exec -o tb_rv_exec &&
./obj_dir/tb_rv_exec || { echo "simulation failed"; exit 1; }

// File: tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

    localparam int PC_BITS     = 32;
    localparam int DRAIN_LIMIT = 8;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_flush;
    logic                       i_valid;
    rv_exec_pkg::alu_op_t       i_op;
    rv_exec_pkg::br_cond_t      i_cond;
    rv_exec_pkg::op1_src_t      i_op1_src;
    rv_exec_pkg::op2_src_t      i_op2_src;
    rv_exec_pkg::reg_idx_t      i_rs1;
    rv_exec_pkg::reg_idx_t      i_rs2;
    rv_exec_pkg::reg_idx_t      i_rd;
    logic                       i_reg_write;
    rv_exec_pkg::word_t         i_imm;
    logic [PC_BITS-1:0]         i_pc;
    wire                        o_valid;
    wire rv_exec_pkg::reg_idx_t o_rd;
    wire rv_exec_pkg::word_t    o_result;
    wire                        o_redirect;
    wire [PC_BITS-1:0]          o_target;

    // fields of the current line of the cases file.
    logic                       c_flush;
    logic                       c_valid;
    rv_exec_pkg::alu_op_t       c_op;
    rv_exec_pkg::br_cond_t      c_cond;
    rv_exec_pkg::op1_src_t      c_op1_src;
    rv_exec_pkg::op2_src_t      c_op2_src;
    rv_exec_pkg::reg_idx_t      c_rs1;
    rv_exec_pkg::reg_idx_t      c_rs2;
    rv_exec_pkg::reg_idx_t      c_rd;
    logic                       c_reg_write;
    rv_exec_pkg::word_t         c_imm;
    logic [PC_BITS-1:0]         c_pc;
    rv_exec_pkg::word_t         c_result;
    logic                       c_redirect;
    logic [PC_BITS-1:0]         c_target;

    // expected outputs, one entry per driven cycle, oldest first.
    logic                       exp_valid [$];
    rv_exec_pkg::reg_idx_t      exp_rd [$];
    rv_exec_pkg::word_t         exp_result [$];
    logic                       exp_redirect [$];
    logic [PC_BITS-1:0]         exp_target [$];

    rv_exec_top #(.P_PC_BITS(PC_BITS)) rv_exec_top_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_flush(i_flush),
        .i_valid(i_valid), .i_op(i_op), .i_cond(i_cond),
        .i_op1_src(i_op1_src), .i_op2_src(i_op2_src),
        .i_rs1(i_rs1), .i_rs2(i_rs2), .i_rd(i_rd), .i_reg_write(i_reg_write),
        .i_imm(i_imm), .i_pc(i_pc),
        .o_valid(o_valid), .o_rd(o_rd), .o_result(o_result),
        .o_redirect(o_redirect), .o_target(o_target)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // ####################################################################
    // compare tasks.
    // ####################################################################
    task automatic check_word(input string what, input rv_exec_pkg::word_t got,
                              input rv_exec_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_idx(input string what, input rv_exec_pkg::reg_idx_t got,
                             input rv_exec_pkg::reg_idx_t exp);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_pc(input string what, input logic [PC_BITS-1:0] got,
                            input logic [PC_BITS-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic clear_line;
        c_flush     = 1'b0;
        c_valid     = 1'b0;
        c_op        = '0;
        c_cond      = '0;
        c_op1_src   = '0;
        c_op2_src   = '0;
        c_rs1       = '0;
        c_rs2       = '0;
        c_rd        = '0;
        c_reg_write = 1'b0;
        c_imm       = '0;
        c_pc        = '0;
        c_result    = '0;
        c_redirect  = 1'b0;
        c_target    = '0;
    endtask

    task automatic drive_inputs;
        i_flush     <= c_flush;
        i_valid     <= c_valid;
        i_op        <= c_op;
        i_cond      <= c_cond;
        i_op1_src   <= c_op1_src;
        i_op2_src   <= c_op2_src;
        i_rs1       <= c_rs1;
        i_rs2       <= c_rs2;
        i_rd        <= c_rd;
        i_reg_write <= c_reg_write;
        i_imm       <= c_imm;
        i_pc        <= c_pc;
    endtask

    task automatic push_expected(input logic valid);
        exp_valid.push_back(valid);
        exp_rd.push_back(c_rd);
        exp_result.push_back(c_result);
        exp_redirect.push_back(c_redirect);
        exp_target.push_back(c_target);
    endtask

    task automatic compare_oldest;
        logic                  valid;
        rv_exec_pkg::reg_idx_t rd;
        rv_exec_pkg::word_t    result;
        logic                  redirect;
        logic [PC_BITS-1:0]    target;
        valid    = exp_valid.pop_front();
        rd       = exp_rd.pop_front();
        result   = exp_result.pop_front();
        redirect = exp_redirect.pop_front();
        target   = exp_target.pop_front();
        check_bit("o_valid", o_valid, valid);
        if (valid)
        begin
            check_idx("o_rd", o_rd, rd);
            check_word("o_result", o_result, result);
            check_bit("o_redirect", o_redirect, redirect);
            check_pc("o_target", o_target, target);
        end
        else
            check_bit("o_redirect", o_redirect, 1'b0); // empty slot.
    endtask

    function automatic bit slots_pending();
        foreach (exp_valid[i])
        begin
            if (exp_valid[i])
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // one line per clock. the slot driven three cycles earlier is checked at the falling edge.
    task automatic step_cycle;
        @(posedge i_clk);
        i_rst <= 1'b0;
        drive_inputs();
        // a flush drops the micro-op in issue and the one entering with it.
        if (c_flush && (exp_valid.size() > 0))
            exp_valid[exp_valid.size()-1] = 1'b0;
        push_expected(c_valid && !c_flush);
        @(negedge i_clk);
        if (exp_valid.size() > 3)
            compare_oldest();
    endtask

    task automatic run_cases;
        int    fd;
        int    n;
        int    status;
        int    lines;
        string text;
        fd = $fopen("rv_exec_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open rv_exec_cases.txt for reading");
        lines = 0;
        while (!$feof(fd))
        begin
            text   = "";
            status = $fgets(text, fd);
            if ((status == 0) || (text.getc(0) == "#") || (text.getc(0) == "\n"))
                continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c_flush, c_valid, c_op, c_cond, c_op1_src, c_op2_src,
                        c_rs1, c_rs2, c_rd, c_reg_write, c_imm, c_pc,
                        c_result, c_redirect, c_target);
            if (n != 15)
                abort_run($sformatf("cases line %0d ends after %0d of 15 fields",
                                    lines + 1, n));
            step_cycle();
            lines++;
        end
        $fclose(fd);
        if (lines == 0)
            abort_run("rv_exec_cases.txt holds no stimulus lines");
    endtask

    // ####################################################################
    // reset, stimulus and drain.
    // ####################################################################
    initial
    begin
        int drain;
        clear_line();
        i_rst <= 1'b1;
        drive_inputs();
        for (int i = 0; i < 15; i++)
            @(posedge i_clk); // the sixteenth edge comes with the first line.
        for (int i = 0; i < 3; i++)
            push_expected(1'b0); // stages are empty out of reset.
        run_cases();
        clear_line();
        drain = 0;
        while (slots_pending() && (drain < DRAIN_LIMIT))
        begin
            step_cycle();
            drain++;
        end
        if (slots_pending())
            abort_run("pipeline still owes results after the drain timeout");
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
#(
    parameter int P_PC_BITS = 32
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_flush,
    input  wire                         i_valid,
    input  wire rv_exec_pkg::alu_op_t   i_op,
    input  wire rv_exec_pkg::br_cond_t  i_cond,
    input  wire rv_exec_pkg::op1_src_t  i_op1_src,
    input  wire rv_exec_pkg::op2_src_t  i_op2_src,
    input  wire rv_exec_pkg::reg_idx_t  i_rs1,
    input  wire rv_exec_pkg::reg_idx_t  i_rs2,
    input  wire rv_exec_pkg::reg_idx_t  i_rd,
    input  wire                         i_reg_write,
    input  wire rv_exec_pkg::word_t     i_imm,
    input  wire [P_PC_BITS-1:0]         i_pc,
    output wire                         o_valid,
    output wire rv_exec_pkg::reg_idx_t  o_rd,
    output wire rv_exec_pkg::word_t     o_result,
    output wire                         o_redirect,
    output wire [P_PC_BITS-1:0]         o_target
);

    wire rv_exec_pkg::reg_idx_t rs1_idx, rs2_idx;
    wire rv_exec_pkg::word_t    rs1_data, rs2_data;
    wire                        wb_en;
    wire rv_exec_pkg::reg_idx_t wb_rd;
    wire rv_exec_pkg::word_t    wb_data;
    wire                        opnd_fwd_valid;    // operand stage holds a register write.
    wire rv_exec_pkg::reg_idx_t opnd_fwd_rd;
    wire                        alu_fwd_valid;

    rv_issue_if #(.P_PC_BITS(P_PC_BITS)) issue_bus ();
    rv_exec_if  #(.P_PC_BITS(P_PC_BITS)) exec_bus ();

    rv_regfile rv_regfile_i
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rd_idx1(rs1_idx), .i_rd_idx2(rs2_idx),
        .o_rd_data1(rs1_data), .o_rd_data2(rs2_data),
        .i_wr_en(wb_en), .i_wr_idx(wb_rd), .i_wr_data(wb_data)
    );

    rv_issue #(.P_PC_BITS(P_PC_BITS)) rv_issue_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_flush(i_flush),
        .i_valid(i_valid), .i_op(i_op), .i_cond(i_cond),
        .i_op1_src(i_op1_src), .i_op2_src(i_op2_src),
        .i_rs1(i_rs1), .i_rs2(i_rs2), .i_rd(i_rd), .i_reg_write(i_reg_write),
        .i_imm(i_imm), .i_pc(i_pc),
        .o_rs1(rs1_idx), .o_rs2(rs2_idx), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .i_fwd_alu_valid(opnd_fwd_valid), .i_fwd_alu_rd(opnd_fwd_rd),
        .i_fwd_wb_valid(alu_fwd_valid), .i_fwd_wb_rd(o_rd),
        .o_issue(issue_bus)
    );

    rv_operand_stage #(.P_PC_BITS(P_PC_BITS)) rv_operand_stage_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_flush(i_flush),
        .i_issue(issue_bus),
        .i_alu_data(o_result), .i_wb_data(wb_data),
        .o_fwd_valid(opnd_fwd_valid), .o_fwd_rd(opnd_fwd_rd),
        .o_exec(exec_bus)
    );

    rv_alu_stage #(.P_PC_BITS(P_PC_BITS)) rv_alu_stage_i
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_exec(exec_bus),
        .o_valid(o_valid), .o_rd(o_rd), .o_result(o_result),
        .o_redirect(o_redirect), .o_target(o_target),
        .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_alu_fwd_valid(alu_fwd_valid)
    );

endmodule

`default_nettype wire

// File: rv_alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_stage
#(
    parameter int P_PC_BITS = 32
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    rv_exec_if.alu                      i_exec,
    output logic                        o_valid,
    output rv_exec_pkg::reg_idx_t       o_rd,
    output rv_exec_pkg::word_t          o_result,
    output logic                        o_redirect,
    output logic [P_PC_BITS-1:0]        o_target,
    output logic                        o_wb_en,
    output rv_exec_pkg::reg_idx_t       o_wb_rd,
    output rv_exec_pkg::word_t          o_wb_data,
    output logic                        o_alu_fwd_valid
);

    rv_exec_pkg::word_t     alu_out;
    rv_exec_pkg::word_t     result;
    logic [4:0]             shamt;
    logic                   is_jump;
    logic                   taken;
    logic [P_PC_BITS-1:0]   target_sum;
    logic [P_PC_BITS-1:0]   target;
    logic                   reg_write_q;

    // ####################################################################
    // alu and branch compare.
    // ####################################################################
    assign shamt = i_exec.op2[4:0];

    always_comb
    begin
        case (i_exec.op)
            rv_exec_pkg::ALU_ADD:  alu_out = i_exec.op1 + i_exec.op2;
            rv_exec_pkg::ALU_SUB:  alu_out = i_exec.op1 - i_exec.op2;
            rv_exec_pkg::ALU_AND:  alu_out = i_exec.op1 & i_exec.op2;
            rv_exec_pkg::ALU_OR:   alu_out = i_exec.op1 | i_exec.op2;
            rv_exec_pkg::ALU_XOR:  alu_out = i_exec.op1 ^ i_exec.op2;
            rv_exec_pkg::ALU_SLT:  alu_out = {31'd0, $signed(i_exec.op1) < $signed(i_exec.op2)};
            rv_exec_pkg::ALU_SLTU: alu_out = {31'd0, i_exec.op1 < i_exec.op2};
            rv_exec_pkg::ALU_SLL:  alu_out = i_exec.op1 << shamt;
            rv_exec_pkg::ALU_SRL:  alu_out = i_exec.op1 >> shamt;
            default:               alu_out = '0;
        endcase
    end

    always_comb
    begin
        case (i_exec.cond)
            rv_exec_pkg::BR_NONE: taken = 1'b0;
            rv_exec_pkg::BR_EQ:   taken = (i_exec.cmp1 == i_exec.cmp2);
            rv_exec_pkg::BR_NE:   taken = (i_exec.cmp1 != i_exec.cmp2);
            rv_exec_pkg::BR_LT:   taken = ($signed(i_exec.cmp1) < $signed(i_exec.cmp2));
            rv_exec_pkg::BR_JAL,
            rv_exec_pkg::BR_JALR: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    assign is_jump = (i_exec.cond == rv_exec_pkg::BR_JAL) || (i_exec.cond == rv_exec_pkg::BR_JALR);
    assign result  = is_jump ? rv_exec_pkg::word_t'(i_exec.pc) + 32'd4 : alu_out; // return address.

    assign target_sum = i_exec.target_base + i_exec.target_offset;
    assign target     = (i_exec.cond == rv_exec_pkg::BR_JALR) ? {target_sum[P_PC_BITS-1:1], 1'b0}
                                                               : target_sum;

    // ####################################################################
    // alu register and writeback register.
    // ####################################################################
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_valid    <= 1'b0;
            o_redirect <= 1'b0;
        end
        else
        begin
            o_valid    <= i_exec.valid;
            o_redirect <= i_exec.valid & taken;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rd        <= i_exec.rd;
        o_result    <= result;
        o_target    <= target;
        reg_write_q <= i_exec.reg_write;
    end

    assign o_alu_fwd_valid = o_valid & reg_write_q;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_wb_en <= 1'b0;
        else
            o_wb_en <= o_alu_fwd_valid;
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd   <= o_rd;
        o_wb_data <= o_result;
    end

endmodule

`default_nettype wire

// File: rv_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_operand_stage
#(
    parameter int P_PC_BITS = 32
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_flush,
    rv_issue_if.operand                 i_issue,
    input  wire rv_exec_pkg::word_t     i_alu_data,
    input  wire rv_exec_pkg::word_t     i_wb_data,
    output logic                        o_fwd_valid,
    output rv_exec_pkg::reg_idx_t       o_fwd_rd,
    rv_exec_if.operand                  o_exec
);

    logic                   valid;
    logic [P_PC_BITS-1:0]   pc;
    rv_exec_pkg::alu_op_t   op;
    rv_exec_pkg::br_cond_t  cond;
    rv_exec_pkg::op1_src_t  op1_src;
    rv_exec_pkg::op2_src_t  op2_src;
    rv_exec_pkg::reg_idx_t  rd;
    logic                   reg_write;
    rv_exec_pkg::word_t     imm;
    rv_exec_pkg::word_t     reg1_data, reg2_data;
    rv_exec_pkg::bypass_t   bp1, bp2;
    rv_exec_pkg::word_t     src1, src2;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
            valid <= 1'b0;
        else
            valid <= i_issue.valid;
    end

    always_ff @(posedge i_clk)
    begin
        pc        <= i_issue.pc;
        op        <= i_issue.op;
        cond      <= i_issue.cond;
        op1_src   <= i_issue.op1_src;
        op2_src   <= i_issue.op2_src;
        rd        <= i_issue.rd;
        reg_write <= i_issue.reg_write;
        imm       <= i_issue.imm;
        reg1_data <= i_issue.reg1_data;
        reg2_data <= i_issue.reg2_data;
        bp1       <= i_issue.bp1;
        bp2       <= i_issue.bp2;
    end

    function automatic rv_exec_pkg::word_t fwd_mux(input rv_exec_pkg::bypass_t bp,
                                                   input rv_exec_pkg::word_t reg_data);
        return (bp == rv_exec_pkg::BP_ALU) ? i_alu_data :
               (bp == rv_exec_pkg::BP_WB)  ? i_wb_data :
               reg_data;
    endfunction

    always_comb
    begin
        src1 = fwd_mux(bp1, reg1_data);
        src2 = fwd_mux(bp2, reg2_data);
    end

    assign o_exec.valid     = valid;
    assign o_exec.pc        = pc;
    assign o_exec.op        = op;
    assign o_exec.cond      = cond;
    assign o_exec.rd        = rd;
    assign o_exec.reg_write = reg_write;
    assign o_exec.op1       = (op1_src == rv_exec_pkg::OP1_PC) ? rv_exec_pkg::word_t'(pc) : src1;
    assign o_exec.op2       = (op2_src == rv_exec_pkg::OP2_IMM) ? imm : src2;
    assign o_exec.cmp1      = src1;
    assign o_exec.cmp2      = src2;

    // jalr adds to the forwarded rs1, every other target is pc relative.
    assign o_exec.target_base   = (cond == rv_exec_pkg::BR_JALR) ? src1[P_PC_BITS-1:0] : pc;
    assign o_exec.target_offset = imm[P_PC_BITS-1:0];

    assign o_fwd_valid = valid & reg_write;
    assign o_fwd_rd    = rd;

endmodule

`default_nettype wire

// File: rv_issue.sv
`timescale 1ns/1ps
`default_nettype none

module rv_issue
#(
    parameter int P_PC_BITS = 32
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_flush,
    input  wire                         i_valid,
    input  wire rv_exec_pkg::alu_op_t   i_op,
    input  wire rv_exec_pkg::br_cond_t  i_cond,
    input  wire rv_exec_pkg::op1_src_t  i_op1_src,
    input  wire rv_exec_pkg::op2_src_t  i_op2_src,
    input  wire rv_exec_pkg::reg_idx_t  i_rs1,
    input  wire rv_exec_pkg::reg_idx_t  i_rs2,
    input  wire rv_exec_pkg::reg_idx_t  i_rd,
    input  wire                         i_reg_write,
    input  wire rv_exec_pkg::word_t     i_imm,
    input  wire [P_PC_BITS-1:0]         i_pc,
    output rv_exec_pkg::reg_idx_t       o_rs1,
    output rv_exec_pkg::reg_idx_t       o_rs2,
    input  wire rv_exec_pkg::word_t     i_rs1_data,
    input  wire rv_exec_pkg::word_t     i_rs2_data,
    input  wire                         i_fwd_alu_valid,
    input  wire rv_exec_pkg::reg_idx_t  i_fwd_alu_rd,
    input  wire                         i_fwd_wb_valid,
    input  wire rv_exec_pkg::reg_idx_t  i_fwd_wb_rd,
    rv_issue_if.issue                   o_issue
);

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
            o_issue.valid <= 1'b0;
        else
            o_issue.valid <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        o_rs1             <= i_rs1;
        o_rs2             <= i_rs2;
        o_issue.pc        <= i_pc;
        o_issue.op        <= i_op;
        o_issue.cond      <= i_cond;
        o_issue.op1_src   <= i_op1_src;
        o_issue.op2_src   <= i_op2_src;
        o_issue.rd        <= i_rd;
        o_issue.reg_write <= i_reg_write;
        o_issue.imm       <= i_imm;
    end

    // ####################################################################
    // bypass decision. the operand stage is the younger producer, so its
    // match is checked first.
    // ####################################################################
    function automatic rv_exec_pkg::bypass_t pick_bypass(input rv_exec_pkg::reg_idx_t rs);
        return (rs == '0)                               ? rv_exec_pkg::BP_NONE :
               (i_fwd_alu_valid && (rs == i_fwd_alu_rd)) ? rv_exec_pkg::BP_ALU :
               (i_fwd_wb_valid && (rs == i_fwd_wb_rd))   ? rv_exec_pkg::BP_WB :
               rv_exec_pkg::BP_NONE;
    endfunction

    always_comb
    begin
        o_issue.bp1       = pick_bypass(o_rs1);
        o_issue.bp2       = pick_bypass(o_rs2);
        o_issue.reg1_data = i_rs1_data;
        o_issue.reg2_data = i_rs2_data;
    end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire rv_exec_pkg::reg_idx_t  i_rd_idx1,
    input  wire rv_exec_pkg::reg_idx_t  i_rd_idx2,
    output rv_exec_pkg::word_t          o_rd_data1,
    output rv_exec_pkg::word_t          o_rd_data2,
    input  wire                         i_wr_en,
    input  wire rv_exec_pkg::reg_idx_t  i_wr_idx,
    input  wire rv_exec_pkg::word_t     i_wr_data
);

    rv_exec_pkg::word_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_idx != '0))
        begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // a write in the same cycle is passed straight to the read port.
    function automatic rv_exec_pkg::word_t read_port(input rv_exec_pkg::reg_idx_t idx);
        return (idx == '0)                       ? '0 :
               (i_wr_en && (i_wr_idx == idx))    ? i_wr_data :
               regs[idx];
    endfunction

    always_comb
    begin
        o_rd_data1 = read_port(i_rd_idx1);
        o_rd_data2 = read_port(i_rd_idx2);
    end

endmodule

`default_nettype wire

// File: rv_pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

// issue stage to operand stage.
interface rv_issue_if
#(
    parameter int P_PC_BITS = 32
);
    logic                   valid;
    logic [P_PC_BITS-1:0]   pc;
    rv_exec_pkg::alu_op_t   op;
    rv_exec_pkg::br_cond_t  cond;
    rv_exec_pkg::op1_src_t  op1_src;
    rv_exec_pkg::op2_src_t  op2_src;
    rv_exec_pkg::reg_idx_t  rd;
    logic                   reg_write;
    rv_exec_pkg::word_t     imm;
    rv_exec_pkg::word_t     reg1_data;
    rv_exec_pkg::word_t     reg2_data;
    rv_exec_pkg::bypass_t   bp1;
    rv_exec_pkg::bypass_t   bp2;

    modport issue (output valid, pc, op, cond, op1_src, op2_src, rd, reg_write, imm,
                   reg1_data, reg2_data, bp1, bp2);
    modport operand (input valid, pc, op, cond, op1_src, op2_src, rd, reg_write, imm,
                     reg1_data, reg2_data, bp1, bp2);
endinterface

// operand stage to alu stage.
interface rv_exec_if
#(
    parameter int P_PC_BITS = 32
);
    logic                   valid;
    logic [P_PC_BITS-1:0]   pc;
    rv_exec_pkg::alu_op_t   op;
    rv_exec_pkg::br_cond_t  cond;
    rv_exec_pkg::reg_idx_t  rd;
    logic                   reg_write;
    rv_exec_pkg::word_t     op1;
    rv_exec_pkg::word_t     op2;
    rv_exec_pkg::word_t     cmp1;    // bypassed rs1 value for the branch compare.
    rv_exec_pkg::word_t     cmp2;
    logic [P_PC_BITS-1:0]   target_base;
    logic [P_PC_BITS-1:0]   target_offset;

    modport operand (output valid, pc, op, cond, rd, reg_write, op1, op2, cmp1, cmp2,
                     target_base, target_offset);
    modport alu (input valid, pc, op, cond, rd, reg_write, op1, op2, cmp1, cmp2,
                 target_base, target_offset);
endinterface

`default_nettype wire

// File: rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  br_cond_t;
    typedef logic        op1_src_t;
    typedef logic        op2_src_t;
    typedef logic [1:0]  bypass_t;

    // ####################################################################
    // alu operations. shifts take the low five bits of operand 2.
    // ####################################################################
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_SLTU = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;

    localparam br_cond_t BR_NONE = 3'd0;
    localparam br_cond_t BR_EQ   = 3'd1;
    localparam br_cond_t BR_NE   = 3'd2;
    localparam br_cond_t BR_LT   = 3'd3; // signed compare.
    localparam br_cond_t BR_JAL  = 3'd4;
    localparam br_cond_t BR_JALR = 3'd5;

    localparam op1_src_t OP1_REG = 1'b0;
    localparam op1_src_t OP1_PC  = 1'b1;
    localparam op2_src_t OP2_REG = 1'b0;
    localparam op2_src_t OP2_IMM = 1'b1;

    localparam bypass_t BP_NONE = 2'd0; // register file data.
    localparam bypass_t BP_ALU  = 2'd1; // alu stage result register.
    localparam bypass_t BP_WB   = 2'd2; // writeback register.

endpackage

`default_nettype wire
